// File: hw/ntm_arith_pkg.sv
package ntm_arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////////////////////////////////////////

  // One operation per vector
  typedef enum logic {
    // A plus B
    OP_ADD = 1'b0,
    // A minus B
    OP_SUB = 1'b1
  } op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Result flags
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic overflow;  // Signed two's-complement overflow
    logic negative;  // Result MSB
    logic zero;      // Result all zeros
  } result_flags_t;

endpackage

// File: hw/ntm_vector_pkg.sv
package ntm_vector_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Element arrival strobes
  ////////////////////////////////////////////////////////////////////////////

  // Independent strobes for the two operand streams
  typedef struct packed {
    logic a_enable;
    logic b_enable;
  } operand_strobe_t;

  ////////////////////////////////////////////////////////////////////////////
  // Overflow status
  ////////////////////////////////////////////////////////////////////////////

  // Width of the saturating overflow count
  localparam int OVF_COUNT_WIDTH = 16;

  typedef struct packed {
    logic [OVF_COUNT_WIDTH-1:0] overflow_count;  // Saturates at all ones
    logic                       sticky;          // Held until next start
  } overflow_status_t;

endpackage

// File: hw/ntm_scalar_integer_adder.sv
`timescale 1ns/1ps

module ntm_scalar_integer_adder #(
  parameter int DATA_SIZE = 64
) (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        START,
  input  ntm_arith_pkg::op_e          OPERATION,
  input  logic [DATA_SIZE-1:0]        DATA_A_IN,
  input  logic [DATA_SIZE-1:0]        DATA_B_IN,
  output logic                        READY,
  output logic [DATA_SIZE-1:0]        DATA_OUT,
  output ntm_arith_pkg::result_flags_t FLAGS_OUT
);

  // Combinational result and effective B sign
  logic [DATA_SIZE-1:0] result;
  logic                 b_sign_eff;
  logic                 overflow;

  always_comb begin
    if (OPERATION == ntm_arith_pkg::OP_SUB) begin
      result     = DATA_A_IN - DATA_B_IN;
      // Subtract adds the negated B so its sign flips
      b_sign_eff = ~DATA_B_IN[DATA_SIZE-1];
    end else begin
      result     = DATA_A_IN + DATA_B_IN;
      b_sign_eff = DATA_B_IN[DATA_SIZE-1];
    end
  end

  // Same operand signs but a different result sign
  assign overflow = (DATA_A_IN[DATA_SIZE-1] == b_sign_eff) &&
                    (result[DATA_SIZE-1] != DATA_A_IN[DATA_SIZE-1]);

  // Ready pulse one cycle after start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  // Result and flags loaded on start only
  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT           <= result;
      FLAGS_OUT.overflow <= overflow;
      FLAGS_OUT.negative <= result[DATA_SIZE-1];
      FLAGS_OUT.zero     <= (result == '0);
    end
  end

  // Next pair never starts while a result is handed back
  a_one_in_flight : assert property (
    @(posedge CLK) disable iff (RST) START |-> !READY
  );

endmodule

// File: hw/ntm_vector_integer_adder.sv
`timescale 1ns/1ps

module ntm_vector_integer_adder #(
  parameter int DATA_SIZE    = 64,
  parameter int CONTROL_SIZE = 16
) (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            START,
  input  ntm_arith_pkg::op_e              OPERATION,
  input  logic [CONTROL_SIZE-1:0]         SIZE_IN,
  input  ntm_vector_pkg::operand_strobe_t STROBE,
  input  logic [DATA_SIZE-1:0]            DATA_A_IN,
  input  logic [DATA_SIZE-1:0]            DATA_B_IN,
  output logic                            READY,
  output logic                            DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0]            DATA_OUT,
  output ntm_arith_pkg::result_flags_t    FLAGS_OUT
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_INPUT,
    ST_COMPUTE
  } state_e;

  state_e state;

  // Vector length and operation latched at start
  logic [CONTROL_SIZE-1:0] length_q;
  ntm_arith_pkg::op_e      op_q;
  logic [CONTROL_SIZE-1:0] index_q;

  // Held operands and their flags
  logic                 a_held;
  logic                 b_held;
  logic [DATA_SIZE-1:0] a_q;
  logic [DATA_SIZE-1:0] b_q;
  logic                 a_take;
  logic                 b_take;
  logic                 last_element;

  // Scalar adder link
  logic                          adder_start;
  logic                          adder_ready;
  logic [DATA_SIZE-1:0]          adder_result;
  ntm_arith_pkg::result_flags_t  adder_flags;

  // Operand present now or held from an earlier cycle
  assign a_take       = a_held | STROBE.a_enable;
  assign b_take       = b_held | STROBE.b_enable;
  assign last_element = (index_q == (length_q - CONTROL_SIZE'(1)));

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ST_IDLE;
      index_q         <= '0;
      a_held          <= 1'b0;
      b_held          <= 1'b0;
      adder_start     <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
    end else begin
      // Pulses by default
      adder_start     <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (START) begin
            index_q <= '0;
            a_held  <= 1'b0;
            b_held  <= 1'b0;
            state   <= ST_INPUT;
          end
        end
        ST_INPUT: begin
          // Complete pair launches the adder next cycle
          if (a_take && b_take) begin
            adder_start <= 1'b1;
            a_held      <= 1'b0;
            b_held      <= 1'b0;
            state       <= ST_COMPUTE;
          end else begin
            a_held <= a_take;
            b_held <= b_take;
          end
        end
        ST_COMPUTE: begin
          // Strobes ignored here
          if (adder_ready) begin
            DATA_OUT_ENABLE <= 1'b1;
            if (last_element) begin
              READY <= 1'b1;
              state <= ST_IDLE;
            end else begin
              index_q <= index_q + CONTROL_SIZE'(1);
              state   <= ST_INPUT;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == ST_IDLE && START) begin
      length_q <= SIZE_IN;
      op_q     <= OPERATION;
    end
    // Late strobe overwrites the held operand
    if (state == ST_INPUT && STROBE.a_enable) a_q <= DATA_A_IN;
    if (state == ST_INPUT && STROBE.b_enable) b_q <= DATA_B_IN;
    if (state == ST_COMPUTE && adder_ready) begin
      DATA_OUT  <= adder_result;
      FLAGS_OUT <= adder_flags;
    end
  end

  ntm_scalar_integer_adder #(
    .DATA_SIZE(DATA_SIZE)
  ) ntm_scalar_integer_adder_inst (
    .CLK      (CLK),
    .RST      (RST),
    .START    (adder_start),
    .OPERATION(op_q),
    .DATA_A_IN(a_q),
    .DATA_B_IN(b_q),
    .READY    (adder_ready),
    .DATA_OUT (adder_result),
    .FLAGS_OUT(adder_flags)
  );

  // Adder answers only while the controller waits for it
  a_ready_in_compute : assert property (
    @(posedge CLK) disable iff (RST) adder_ready |-> (state == ST_COMPUTE)
  );

  // Element index stays inside the latched length
  a_index_in_range : assert property (
    @(posedge CLK) disable iff (RST) (state != ST_IDLE) |-> (index_q < length_q)
  );

endmodule

// File: hw/ntm_vector_overflow_monitor.sv
`timescale 1ns/1ps

module ntm_vector_overflow_monitor (
  input  logic                             CLK,
  input  logic                             RST,
  input  logic                             START,
  input  logic                             DATA_OUT_ENABLE,
  input  logic                             OVERFLOW,
  output ntm_vector_pkg::overflow_status_t STATUS
);

  ////////////////////////////////////////////////////////////////////////////
  // Per-vector overflow tracking
  ////////////////////////////////////////////////////////////////////////////

  // Counter already at its top value
  logic count_full;

  assign count_full = &STATUS.overflow_count;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      STATUS.overflow_count <= '0;
      STATUS.sticky         <= 1'b0;
    end else if (START) begin
      // New vector wins over a coincident result
      STATUS.overflow_count <= '0;
      STATUS.sticky         <= 1'b0;
    end else if (DATA_OUT_ENABLE && OVERFLOW) begin
      STATUS.sticky <= 1'b1;
      // Saturate, never wrap
      if (!count_full) begin
        STATUS.overflow_count <= STATUS.overflow_count +
                                 ntm_vector_pkg::OVF_COUNT_WIDTH'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Any counted overflow leaves the sticky flag up
  a_sticky_with_count : assert property (
    @(posedge CLK) disable iff (RST)
    (STATUS.overflow_count != '0) |-> STATUS.sticky
  );

endmodule

// File: hw/ntm_vector_integer_unit.sv
`timescale 1ns/1ps

module ntm_vector_integer_unit #(
  parameter int DATA_SIZE    = 64,
  parameter int CONTROL_SIZE = 16
) (
  input  logic                             CLK,
  input  logic                             RST,
  input  logic                             START,
  input  ntm_arith_pkg::op_e               OPERATION,
  input  logic [CONTROL_SIZE-1:0]          SIZE_IN,
  input  ntm_vector_pkg::operand_strobe_t  STROBE,
  input  logic [DATA_SIZE-1:0]             DATA_A_IN,
  input  logic [DATA_SIZE-1:0]             DATA_B_IN,
  output logic                             READY,
  output logic                             DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0]             DATA_OUT,
  output ntm_arith_pkg::result_flags_t     FLAGS_OUT,
  output ntm_vector_pkg::overflow_status_t STATUS
);

  // Element sequencing and arithmetic
  ntm_vector_integer_adder #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) ntm_vector_integer_adder_inst (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .OPERATION      (OPERATION),
    .SIZE_IN        (SIZE_IN),
    .STROBE         (STROBE),
    .DATA_A_IN      (DATA_A_IN),
    .DATA_B_IN      (DATA_B_IN),
    .READY          (READY),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .DATA_OUT       (DATA_OUT),
    .FLAGS_OUT      (FLAGS_OUT)
  );

  // Overflow count watches the result stream
  ntm_vector_overflow_monitor ntm_vector_overflow_monitor_inst (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .OVERFLOW       (FLAGS_OUT.overflow),
    .STATUS         (STATUS)
  );

endmodule

// File: tb/ntm_tb_clock.sv
`timescale 1ns/1ps

module ntm_tb_clock (
  output logic CLK,
  output logic RST
);

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Reset held over the first 16 rising edges, released just after an edge
  initial begin
    RST = 1'b1;
    repeat (16) @(posedge CLK);
    #2;
    RST = 1'b0;
  end

endmodule

// File: tb/ntm_vector_integer_unit_tb.sv
`timescale 1ns/1ps

module ntm_vector_integer_unit_tb;

  localparam int TIMEOUT = 40;

  logic                             clk;
  logic                             rst;
  logic                             start;
  ntm_arith_pkg::op_e               operation;
  logic [15:0]                      size_in;
  ntm_vector_pkg::operand_strobe_t  strobe;
  logic [31:0]                      data_a;
  logic [31:0]                      data_b;
  logic                             ready;
  logic                             data_out_enable;
  logic [31:0]                      data_out;
  ntm_arith_pkg::result_flags_t     flags_out;
  ntm_vector_pkg::overflow_status_t status;
  logic [31:0]                      rand_state;
  int                               ovf_expected;

  ntm_tb_clock ntm_tb_clock_inst (
    .CLK(clk),
    .RST(rst)
  );

  ntm_vector_integer_unit #(
    .DATA_SIZE   (32),
    .CONTROL_SIZE(16)
  ) ntm_vector_integer_unit_inst (
    .CLK            (clk),
    .RST            (rst),
    .START          (start),
    .OPERATION      (operation),
    .SIZE_IN        (size_in),
    .STROBE         (strobe),
    .DATA_A_IN      (data_a),
    .DATA_B_IN      (data_b),
    .READY          (ready),
    .DATA_OUT_ENABLE(data_out_enable),
    .DATA_OUT       (data_out),
    .FLAGS_OUT      (flags_out),
    .STATUS         (status)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // LCG operand source
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Exact 64-bit arithmetic followed by wrap and range test
  task automatic model(input ntm_arith_pkg::op_e op, input logic [31:0] a,
                       input logic [31:0] b, output logic [31:0] res,
                       output ntm_arith_pkg::result_flags_t fl);
    longint exact;
    if (op == ntm_arith_pkg::OP_SUB)
      exact = longint'(signed'(a)) - longint'(signed'(b));
    else
      exact = longint'(signed'(a)) + longint'(signed'(b));
    res         = exact[31:0];
    fl.overflow = (exact > 64'sd2147483647) || (exact < -64'sd2147483648);
    fl.negative = res[31];
    fl.zero     = (res == 32'd0);
  endtask

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_with_error($sformatf("[FAIL] %0t ns: %s is %h, expected %h",
                                     $time, what, got, exp));
  endtask

  // Advance to just after the next rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    @(posedge clk);
    while (rst) begin
      waited++;
      if (waited > TIMEOUT)
        stop_with_error("Timeout: reset was never released");
      @(posedge clk);
    end
    #2;
  endtask

  // Counts edges until the result strobe and drops strobes after the first
  task automatic wait_result(output int cycles);
    cycles = 0;
    do begin
      step();
      strobe = '0;
      cycles++;
      if (cycles > TIMEOUT)
        stop_with_error("Timeout: DATA_OUT_ENABLE never arrived");
    end while (!data_out_enable);
  endtask

  task automatic start_vector(input ntm_arith_pkg::op_e op, input int len);
    start        = 1'b1;
    operation    = op;
    size_in      = 16'(len);
    ovf_expected = 0;
    step();
    start = 1'b0;
  endtask

  // Strobe mode 0 for both at once, 1 for A first and 2 for B first
  // Junk adds strobes during compute
  task automatic run_element(input ntm_arith_pkg::op_e op, input logic [31:0] a,
                             input logic [31:0] b, input int mode, input bit last,
                             input bit junk);
    logic [31:0]                  exp_res;
    ntm_arith_pkg::result_flags_t exp_fl;
    int                           cycles;
    int                           lead;
    model(op, a, b, exp_res, exp_fl);
    lead   = 0;
    data_a = a;
    data_b = b;
    if (mode == 0) begin
      strobe = '1;
    end else begin
      strobe.a_enable = (mode == 1);
      strobe.b_enable = (mode == 2);
      step();
      // Idle gap while the first operand stays held
      strobe = '0;
      step();
      strobe.a_enable = (mode == 2);
      strobe.b_enable = (mode == 1);
    end
    if (junk) begin
      step();
      data_a = ~a;
      data_b = a ^ b;
      strobe = '1;
      lead   = 1;
    end
    wait_result(cycles);
    check("latency", 32'(cycles + lead), 32'd3);
    check("DATA_OUT", data_out, exp_res);
    check("overflow flag", 32'(flags_out.overflow), 32'(exp_fl.overflow));
    check("negative flag", 32'(flags_out.negative), 32'(exp_fl.negative));
    check("zero flag", 32'(flags_out.zero), 32'(exp_fl.zero));
    check("READY", 32'(ready), 32'(last));
    if (exp_fl.overflow)
      ovf_expected++;
  endtask

  // STATUS settles one cycle after the last result
  task automatic check_status();
    step();
    check("overflow count", 32'(status.overflow_count), 32'(ovf_expected));
    check("sticky flag", 32'(status.sticky), 32'(ovf_expected != 0));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_add_vector();
    start_vector(ntm_arith_pkg::OP_ADD, 8);
    for (int i = 0; i < 8; i++)
      run_element(ntm_arith_pkg::OP_ADD, next_rand(), next_rand(), 0, i == 7, 1'b0);
    check_status();
  endtask

  task automatic test_sub_mixed_strobes();
    start_vector(ntm_arith_pkg::OP_SUB, 6);
    // Zero result followed by a negative one
    run_element(ntm_arith_pkg::OP_SUB, 32'h1234_5678, 32'h1234_5678, 1, 1'b0, 1'b0);
    run_element(ntm_arith_pkg::OP_SUB, 32'd5, 32'd9, 2, 1'b0, 1'b0);
    for (int i = 2; i < 6; i++)
      run_element(ntm_arith_pkg::OP_SUB, next_rand(), next_rand(), i % 3, i == 5, 1'b0);
    check_status();
  endtask

  task automatic test_overflow();
    start_vector(ntm_arith_pkg::OP_ADD, 3);
    run_element(ntm_arith_pkg::OP_ADD, 32'h7fff_ffff, 32'd1, 0, 1'b0, 1'b0);
    run_element(ntm_arith_pkg::OP_ADD, 32'd10, 32'd20, 0, 1'b0, 1'b0);
    run_element(ntm_arith_pkg::OP_ADD, 32'h8000_0000, 32'h8000_0000, 0, 1'b1, 1'b0);
    check_status();
    start_vector(ntm_arith_pkg::OP_SUB, 3);
    run_element(ntm_arith_pkg::OP_SUB, 32'h8000_0000, 32'd1, 0, 1'b0, 1'b0);
    run_element(ntm_arith_pkg::OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 1, 1'b0, 1'b0);
    run_element(ntm_arith_pkg::OP_SUB, 32'd3, 32'd3, 0, 1'b1, 1'b0);
    check_status();
  endtask

  task automatic test_restart_single();
    // Previous vector left overflows behind
    start_vector(ntm_arith_pkg::OP_ADD, 1);
    check("count after start", 32'(status.overflow_count), 32'd0);
    check("sticky after start", 32'(status.sticky), 32'd0);
    run_element(ntm_arith_pkg::OP_ADD, next_rand(), next_rand(), 0, 1'b1, 1'b0);
    check_status();
  endtask

  task automatic test_start_ignored();
    start_vector(ntm_arith_pkg::OP_ADD, 3);
    run_element(ntm_arith_pkg::OP_ADD, next_rand(), next_rand(), 0, 1'b0, 1'b0);
    // Stray start with other length and op reaches only the monitor
    start     = 1'b1;
    operation = ntm_arith_pkg::OP_SUB;
    size_in   = 16'd1;
    step();
    start        = 1'b0;
    ovf_expected = 0;
    run_element(ntm_arith_pkg::OP_ADD, next_rand(), next_rand(), 0, 1'b0, 1'b0);
    run_element(ntm_arith_pkg::OP_ADD, next_rand(), next_rand(), 2, 1'b1, 1'b0);
    check_status();
  endtask

  task automatic test_extra_strobe();
    start_vector(ntm_arith_pkg::OP_ADD, 2);
    run_element(ntm_arith_pkg::OP_ADD, next_rand(), next_rand(), 0, 1'b0, 1'b1);
    // Staggered strobes expose a junk operand left held
    run_element(ntm_arith_pkg::OP_ADD, next_rand(), next_rand(), 1, 1'b1, 1'b0);
    check_status();
  endtask

  initial begin
    start        = 1'b0;
    operation    = ntm_arith_pkg::OP_ADD;
    size_in      = '0;
    strobe       = '0;
    data_a       = '0;
    data_b       = '0;
    rand_state   = 32'hb036075e;
    ovf_expected = 0;
    wait_reset();
    test_add_vector();
    test_sub_mixed_strobes();
    test_overflow();
    test_restart_single();
    test_start_ignored();
    test_extra_strobe();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: ntm_vector_integer_unit.f
hw/ntm_arith_pkg.sv
hw/ntm_vector_pkg.sv
hw/ntm_scalar_integer_adder.sv
hw/ntm_vector_integer_adder.sv
hw/ntm_vector_overflow_monitor.sv
hw/ntm_vector_integer_unit.sv
tb/ntm_tb_clock.sv
tb/ntm_vector_integer_unit_tb.sv

// File: Makefile
# Verilator build and run for the vector integer unit testbench

VERILATOR ?= verilator
TOP       ?= ntm_vector_integer_unit_tb
FILELIST  ?= ntm_vector_integer_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "Simulation ended without passing"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
